//--- source/spi_pkg.sv
//--------------------------------------------------------------------------
// SPI manager subsystem shared definitions
// Widths, enums, command and result records, timing constants
//--------------------------------------------------------------------------

package spi_pkg;

  //--------------------------------------------------------------------------
  // Sizes and timing
  //--------------------------------------------------------------------------

  // Bits per transfer, MSB first
  localparam int SPI_BITS = 8;
  // One chip select per device
  localparam int SPI_DEV_COUNT = 2;
  // Minimum SCLK half period in clock cycles
  // Leaves room for a device to see the edge and move MISO
  localparam int SPI_HALF_MIN = 4;
  // Divider field width
  localparam int SPI_DIV_WIDTH = 4;
  // Two SCLK edges per bit
  localparam int SPI_EDGES = 2 * SPI_BITS;
  // Longest half period, divider at full scale
  localparam int SPI_HALF_MAX = (2 ** SPI_DIV_WIDTH) - 1 + SPI_HALF_MIN;
  // Half counter runs from SPI_HALF_MAX-1 down to 0
  localparam int SPI_HALF_WIDTH = $clog2(SPI_HALF_MAX);
  // Edge counter reaches SPI_EDGES
  localparam int SPI_EDGE_WIDTH = $clog2(SPI_EDGES + 1);

  //--------------------------------------------------------------------------
  // Scalar types
  //--------------------------------------------------------------------------

  typedef logic [SPI_BITS-1:0]       spi_byte_t;
  typedef logic [SPI_DIV_WIDTH-1:0]  spi_div_t;
  typedef logic                      spi_dev_t;
  typedef logic [SPI_HALF_WIDTH-1:0] spi_half_t;
  typedef logic [SPI_EDGE_WIDTH-1:0] spi_edge_t;

  // Upper bit CPOL, lower bit CPHA
  typedef enum logic [1:0] {
    SPI_MODE0 = 2'b00,
    SPI_MODE1 = 2'b01,
    SPI_MODE2 = 2'b10,
    SPI_MODE3 = 2'b11
  } spi_mode_t;

  // Shift engine: LEAD waits before an odd edge, TRAIL before an even one
  typedef enum logic [1:0] {
    ENGINE_IDLE   = 2'b00,
    ENGINE_LEAD   = 2'b01,
    ENGINE_TRAIL  = 2'b10,
    ENGINE_FINISH = 2'b11
  } spi_engine_state_t;

  // User command, 15 bits
  typedef struct packed {
    spi_dev_t  device;
    spi_mode_t mode;
    spi_div_t  divider;
    spi_byte_t data;
  } spi_command_t;

  // Received byte tagged with its source, 9 bits
  typedef struct packed {
    spi_dev_t  device;
    spi_byte_t data;
  } spi_result_t;

endpackage

//--- source/spi_command_decode.sv
//--------------------------------------------------------------------------
// SPI command decode
// Accepts a start while idle, latches the command, drives CS and busy
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module spi_command_decode (
  input  logic                              clock,
  input  logic                              reset_n,
  input  logic                              start,
  input  spi_pkg::spi_command_t             command,
  input  logic                              finish,
  output logic                              go,
  output spi_pkg::spi_mode_t                mode,
  output spi_pkg::spi_div_t                 divider,
  output spi_pkg::spi_byte_t                tx_data,
  output spi_pkg::spi_dev_t                 device,
  output logic [spi_pkg::SPI_DEV_COUNT-1:0] cs,
  output logic                              busy
);

  // Start is only honoured while no transfer runs
  logic accept;

  assign accept = start && !busy;

  //--------------------------------------------------------------------------
  // Control state
  //--------------------------------------------------------------------------

  // Busy, go, CS and mode all change on the accepting edge
  // Idle SCLK level follows mode, so mode starts at 0 to park SCLK low
  always_ff @(posedge clock) begin
    if (!reset_n) begin
      busy <= 1'b0;
      go   <= 1'b0;
      cs   <= '1;
      mode <= spi_pkg::SPI_MODE0;
    end else begin
      // Go is a single-cycle strobe
      go <= 1'b0;
      if (accept) begin
        busy <= 1'b1;
        go   <= 1'b1;
        mode <= command.mode;
        // Active low, only the addressed device
        for (int i = 0; i < spi_pkg::SPI_DEV_COUNT; i++) begin
          cs[i] <= (spi_pkg::spi_dev_t'(i) != command.device);
        end
      end else if (busy && finish) begin
        // Release on the edge that samples finish
        busy <= 1'b0;
        cs   <= '1;
      end
    end
  end

  // Rest of the command, held steady until the next accept
  always_ff @(posedge clock) begin
    if (accept) begin
      divider <= command.divider;
      tx_data <= command.data;
      device  <= command.device;
    end
  end

endmodule

//--- source/spi_shift_engine.sv
//--------------------------------------------------------------------------
// SPI shift engine
// Generates SCLK from the divider, shifts MOSI out and MISO in, MSB first
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module spi_shift_engine (
  input  logic               clock,
  input  logic               reset_n,
  input  logic               go,
  input  spi_pkg::spi_mode_t mode,
  input  spi_pkg::spi_div_t  divider,
  input  spi_pkg::spi_byte_t tx_data,
  input  logic               miso,
  output logic               sclk,
  output logic               mosi,
  output logic               finish,
  output spi_pkg::spi_byte_t rx_data
);

  spi_pkg::spi_engine_state_t state;

  // Half period timing
  spi_pkg::spi_half_t half_count;
  spi_pkg::spi_half_t half_reload;
  logic               half_done;

  // Edges made so far in this transfer
  spi_pkg::spi_edge_t edge_count;

  // Shift registers
  spi_pkg::spi_byte_t tx_shift;
  spi_pkg::spi_byte_t rx_shift;

  logic sclk_q;
  logic cpol;
  logic cpha;
  logic edge_now;
  logic leading;
  logic sample_now;
  logic shift_now;

  //--------------------------------------------------------------------------
  // Edge decode
  //--------------------------------------------------------------------------

  assign cpol = mode[1];
  assign cpha = mode[0];

  // Half period is divider + SPI_HALF_MIN cycles, counted down to 0
  assign half_reload = spi_pkg::spi_half_t'(divider)
                     + spi_pkg::spi_half_t'(spi_pkg::SPI_HALF_MIN - 1);
  assign half_done   = (half_count == '0);

  // An SCLK edge is made when a LEAD or TRAIL wait runs out
  assign leading  = (state == spi_pkg::ENGINE_LEAD);
  assign edge_now = half_done && (leading || (state == spi_pkg::ENGINE_TRAIL));

  // CPHA 0 samples odd edges, CPHA 1 samples even edges
  assign sample_now = edge_now && (leading ^ cpha);
  // MOSI moves on the other edges, never on edge 1
  assign shift_now  = edge_now && !(leading ^ cpha) && (edge_count != '0);

  //--------------------------------------------------------------------------
  // Control FSM
  //--------------------------------------------------------------------------

  always_ff @(posedge clock) begin
    if (!reset_n) begin
      state      <= spi_pkg::ENGINE_IDLE;
      half_count <= '0;
      edge_count <= '0;
      sclk_q     <= 1'b0;
      finish     <= 1'b0;
    end else begin
      finish <= 1'b0;
      // Free-running countdown, reloaded below on each expiry
      if (!half_done) begin
        half_count <= half_count - 1'b1;
      end
      case (state)
        spi_pkg::ENGINE_IDLE: begin
          if (go) begin
            // SCLK held at CPOL for the lead-in half period
            state      <= spi_pkg::ENGINE_LEAD;
            half_count <= half_reload;
            edge_count <= '0;
            sclk_q     <= cpol;
          end
        end
        spi_pkg::ENGINE_LEAD: begin
          if (half_done) begin
            state      <= spi_pkg::ENGINE_TRAIL;
            half_count <= half_reload;
            edge_count <= edge_count + 1'b1;
            sclk_q     <= ~sclk_q;
          end
        end
        spi_pkg::ENGINE_TRAIL: begin
          if (half_done) begin
            half_count <= half_reload;
            edge_count <= edge_count + 1'b1;
            sclk_q     <= ~sclk_q;
            // Last edge brings SCLK back to CPOL
            if (edge_count == spi_pkg::spi_edge_t'(spi_pkg::SPI_EDGES - 1)) begin
              state <= spi_pkg::ENGINE_FINISH;
            end else begin
              state <= spi_pkg::ENGINE_LEAD;
            end
          end
        end
        spi_pkg::ENGINE_FINISH: begin
          // One trailing half period, then the end strobe
          if (half_done) begin
            state  <= spi_pkg::ENGINE_IDLE;
            finish <= 1'b1;
          end
        end
        default: state <= spi_pkg::ENGINE_IDLE;
      endcase
    end
  end

  //--------------------------------------------------------------------------
  // Data path
  //--------------------------------------------------------------------------

  // MISO is taken on the same clock edge that moves SCLK
  always_ff @(posedge clock) begin
    if ((state == spi_pkg::ENGINE_IDLE) && go) begin
      tx_shift <= tx_data;
    end else if (shift_now) begin
      tx_shift <= {tx_shift[spi_pkg::SPI_BITS-2:0], 1'b0};
    end
    if (sample_now) begin
      rx_shift <= {rx_shift[spi_pkg::SPI_BITS-2:0], miso};
    end
  end

  // While idle SCLK tracks the latched mode so CS and CPOL move together
  assign sclk    = (state == spi_pkg::ENGINE_IDLE) ? cpol : sclk_q;
  assign mosi    = tx_shift[spi_pkg::SPI_BITS-1];
  assign rx_data = rx_shift;

endmodule

//--- source/spi_result_capture.sv
//--------------------------------------------------------------------------
// SPI result capture
// Registers the received byte with its device and pulses done
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module spi_result_capture (
  input  logic                 clock,
  input  logic                 reset_n,
  input  logic                 finish,
  input  spi_pkg::spi_byte_t   rx_data,
  input  spi_pkg::spi_dev_t    device,
  output logic                 done,
  output spi_pkg::spi_result_t result
);

  // Done follows finish by one cycle, one pulse per transfer
  always_ff @(posedge clock) begin
    if (!reset_n) begin
      done <= 1'b0;
    end else begin
      done <= finish;
    end
  end

  // Result reads zero after reset
  // Otherwise holds the last transfer until the next one ends
  always_ff @(posedge clock) begin
    if (!reset_n) begin
      result <= '0;
    end else if (finish) begin
      // Device is still latched in decode on this edge
      result.device <= device;
      result.data   <= rx_data;
    end
  end

endmodule

//--- source/spi_echo_subordinate.sv
//--------------------------------------------------------------------------
// SPI echo device, oversampled on the system clock
// Shifts MOSI in and returns the previous byte on a tri-stated MISO
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module spi_echo_subordinate #(
  // 1 samples on rising SCLK (modes 0/3), 0 on falling SCLK (modes 1/2)
  parameter bit sample_on_rising = 1'b1
) (
  input  logic clock,
  input  logic reset_n,
  input  logic sclk,
  input  logic mosi,
  input  logic cs,
  output tri   miso
);

  // Delayed copies for edge detection
  logic sclk_prev;
  logic cs_prev;

  logic selected;
  logic sample_edge;
  logic shifted;
  logic tx_bit;

  spi_pkg::spi_byte_t rx_shift;

  always_ff @(posedge clock) begin
    if (!reset_n) begin
      sclk_prev <= 1'b0;
      cs_prev   <= 1'b1;
    end else begin
      sclk_prev <= sclk;
      cs_prev   <= cs;
    end
  end

  // Selected only after CS has been low a full cycle
  // Masks the CPOL change that lands together with CS falling
  assign selected = !cs && !cs_prev;

  // Edge seen one cycle after SCLK moves
  assign sample_edge = selected && (sample_on_rising ? (sclk && !sclk_prev)
                                                     : (!sclk && sclk_prev));

  //--------------------------------------------------------------------------
  // Shift and echo
  //--------------------------------------------------------------------------

  // Byte history starts at 00
  always_ff @(posedge clock) begin
    if (!reset_n) begin
      rx_shift <= '0;
      shifted  <= 1'b0;
      tx_bit   <= 1'b0;
    end else begin
      shifted <= sample_edge;
      if (sample_edge) begin
        rx_shift <= {rx_shift[spi_pkg::SPI_BITS-2:0], mosi};
      end
      // MISO moves one cycle after the shift
      // After 8 shifts this is the MSB of the byte just received
      if (shifted) begin
        tx_bit <= rx_shift[spi_pkg::SPI_BITS-1];
      end
    end
  end

  // Bus released whenever not addressed
  assign miso = cs ? 1'bz : tx_bit;

endmodule

//--- source/spi_subsystem.sv
//--------------------------------------------------------------------------
// SPI subsystem top: manager blocks and two echo devices on one bus
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module spi_subsystem (
  input  logic                 clock,
  input  logic                 reset_n,
  input  logic                 start,
  input  spi_pkg::spi_command_t command,
  output logic                 busy,
  output logic                 done,
  output spi_pkg::spi_result_t result
);

  //--------------------------------------------------------------------------
  // Manager internals
  //--------------------------------------------------------------------------

  // Decode to engine
  logic               go;
  spi_pkg::spi_mode_t mode;
  spi_pkg::spi_div_t  divider;
  spi_pkg::spi_byte_t tx_data;

  // Decode to capture
  spi_pkg::spi_dev_t device;

  // Engine to decode and capture
  logic               finish;
  spi_pkg::spi_byte_t rx_data;

  // SPI bus, MISO shared by both devices
  logic [spi_pkg::SPI_DEV_COUNT-1:0] cs;
  logic                              sclk;
  logic                              mosi;
  tri                                miso;

  spi_command_decode u_decode (
    .clock   (clock),
    .reset_n (reset_n),
    .start   (start),
    .command (command),
    .finish  (finish),
    .go      (go),
    .mode    (mode),
    .divider (divider),
    .tx_data (tx_data),
    .device  (device),
    .cs      (cs),
    .busy    (busy)
  );

  spi_shift_engine u_engine (
    .clock   (clock),
    .reset_n (reset_n),
    .go      (go),
    .mode    (mode),
    .divider (divider),
    .tx_data (tx_data),
    .miso    (miso),
    .sclk    (sclk),
    .mosi    (mosi),
    .finish  (finish),
    .rx_data (rx_data)
  );

  spi_result_capture u_capture (
    .clock   (clock),
    .reset_n (reset_n),
    .finish  (finish),
    .rx_data (rx_data),
    .device  (device),
    .done    (done),
    .result  (result)
  );

  //--------------------------------------------------------------------------
  // Devices
  //--------------------------------------------------------------------------

  // Device 0 serves modes 0 and 3
  spi_echo_subordinate #(
    .sample_on_rising (1'b1)
  ) u_device0 (
    .clock   (clock),
    .reset_n (reset_n),
    .sclk    (sclk),
    .mosi    (mosi),
    .cs      (cs[0]),
    .miso    (miso)
  );

  // Device 1 serves modes 1 and 2
  spi_echo_subordinate #(
    .sample_on_rising (1'b0)
  ) u_device1 (
    .clock   (clock),
    .reset_n (reset_n),
    .sclk    (sclk),
    .mosi    (mosi),
    .cs      (cs[1]),
    .miso    (miso)
  );

endmodule

//--- tests/spi_subsystem_tb.sv
//--------------------------------------------------------------------------
// SPI subsystem testbench
// Table of transfers checked against a per-device echo history model
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module spi_subsystem_tb;

  localparam int ENTRY_COUNT = 12;
  localparam int CLOCK_NS    = 40;
  // One transfer at the slowest divider, plus handshake margin
  localparam int TRANSFER_CYCLES = 16 * (15 + spi_pkg::SPI_HALF_MIN) + 40;
  localparam longint WATCHDOG_NS = 2 * ENTRY_COUNT * TRANSFER_CYCLES * CLOCK_NS;

  // One row of the test table
  typedef struct packed {
    spi_pkg::spi_dev_t  device;
    spi_pkg::spi_mode_t mode;
    spi_pkg::spi_div_t  divider;
    spi_pkg::spi_byte_t data;
    logic               use_random;
    logic               extra_start;
  } entry_t;

  logic                  clock;
  logic                  reset_n;
  logic                  start;
  spi_pkg::spi_command_t command;
  logic                  busy;
  logic                  done;
  spi_pkg::spi_result_t  result;

  entry_t             entries [ENTRY_COUNT];
  // Last byte each device received, as the echo model sees it
  spi_pkg::spi_byte_t history [spi_pkg::SPI_DEV_COUNT];
  logic [31:0]        rand_state;
  int                 error_count;
  int                 check_count;
  int                 test_errors;

  spi_subsystem u_dut (
    .clock   (clock),
    .reset_n (reset_n),
    .start   (start),
    .command (command),
    .busy    (busy),
    .done    (done),
    .result  (result)
  );

  initial begin
    clock = 1'b0;
    forever #(CLOCK_NS / 2) clock = ~clock;
  end

  //--------------------------------------------------------------------------
  // Helpers
  //--------------------------------------------------------------------------

  // 32-bit xorshift step
  function automatic logic [31:0] next_random(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_result(input string name, input spi_pkg::spi_result_t expected,
                              input spi_pkg::spi_result_t actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      test_errors++;
      $display("error: %s expected 0x%03h actual 0x%03h", name, expected, actual);
    end
  endtask

  task automatic check_level(input string name, input logic expected, input logic actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      test_errors++;
      $display("error: %s expected 0x%01h actual 0x%01h", name, expected, actual);
    end
  endtask

  // One table row: start, optional ignored start, wait for done, check
  task automatic apply_entry(input int idx);
    entry_t               e;
    spi_pkg::spi_result_t expected;
    int                   cycles;
    bit                   seen_done;
    e = entries[idx];
    test_errors = 0;
    if (e.use_random) begin
      rand_state = next_random(rand_state);
      e.data = rand_state[7:0];
    end
    // Device answers with what it got in its previous transfer
    expected.device = e.device;
    expected.data   = history[e.device];
    history[e.device] = e.data;
    @(negedge clock);
    start           = 1'b1;
    command.device  = e.device;
    command.mode    = e.mode;
    command.divider = e.divider;
    command.data    = e.data;
    @(negedge clock);
    start = 1'b0;
    check_level("busy", 1'b1, busy);
    cycles    = 0;
    seen_done = 1'b0;
    while (!seen_done && (cycles < 2 * TRANSFER_CYCLES)) begin
      // Second start mid-transfer, other device and other byte
      if (e.extra_start && (cycles == 2)) begin
        start          = 1'b1;
        command.device = ~e.device;
        command.data   = ~e.data;
      end else begin
        start = 1'b0;
      end
      @(negedge clock);
      cycles++;
      if (done) begin
        seen_done = 1'b1;
      end else begin
        check_level("busy", 1'b1, busy);
      end
    end
    start = 1'b0;
    if (!seen_done) begin
      error_count++;
      test_errors++;
      $display("test %0d: no done pulse within %0d cycles", idx, 2 * TRANSFER_CYCLES);
    end else begin
      // Busy drops on the same edge that raises done
      check_level("busy", 1'b0, busy);
      check_result("result", expected, result);
      @(negedge clock);
      check_level("done", 1'b0, done);
      check_level("busy", 1'b0, busy);
    end
    $display("test %0d dev %0d mode %0d div %0d tx 0x%02h: %s", idx, e.device, e.mode,
             e.divider, e.data, (test_errors == 0) ? "ok" : "failed");
  endtask

  //--------------------------------------------------------------------------
  // Main sequence
  //--------------------------------------------------------------------------

  initial begin
    start       = 1'b0;
    command     = '0;
    reset_n     = 1'b0;
    error_count = 0;
    check_count = 0;
    test_errors = 0;
    rand_state  = 32'd75;
    history[0]  = '0;
    history[1]  = '0;
    // device, mode, divider, data, random data, second start
    entries[0]  = '{1'b0, spi_pkg::SPI_MODE0, 4'd0,  8'hA5, 1'b0, 1'b0};
    entries[1]  = '{1'b1, spi_pkg::SPI_MODE1, 4'd0,  8'h3C, 1'b0, 1'b0};
    entries[2]  = '{1'b0, spi_pkg::SPI_MODE3, 4'd3,  8'h00, 1'b1, 1'b0};
    entries[3]  = '{1'b0, spi_pkg::SPI_MODE0, 4'd15, 8'h00, 1'b1, 1'b0};
    entries[4]  = '{1'b0, spi_pkg::SPI_MODE3, 4'd7,  8'hC3, 1'b0, 1'b0};
    entries[5]  = '{1'b1, spi_pkg::SPI_MODE2, 4'd2,  8'h00, 1'b1, 1'b0};
    entries[6]  = '{1'b1, spi_pkg::SPI_MODE1, 4'd9,  8'h5A, 1'b0, 1'b0};
    entries[7]  = '{1'b1, spi_pkg::SPI_MODE2, 4'd15, 8'h00, 1'b1, 1'b0};
    entries[8]  = '{1'b0, spi_pkg::SPI_MODE0, 4'd1,  8'h00, 1'b1, 1'b1};
    entries[9]  = '{1'b1, spi_pkg::SPI_MODE1, 4'd4,  8'h00, 1'b1, 1'b1};
    entries[10] = '{1'b0, spi_pkg::SPI_MODE3, 4'd0,  8'hFF, 1'b0, 1'b0};
    entries[11] = '{1'b1, spi_pkg::SPI_MODE2, 4'd6,  8'h81, 1'b0, 1'b0};
    repeat (5) @(negedge clock);
    reset_n = 1'b1;
    @(negedge clock);
    check_level("busy", 1'b0, busy);
    check_level("done", 1'b0, done);
    check_result("result", '0, result);
    $display("reset state: %s", (test_errors == 0) ? "ok" : "failed");
    for (int i = 0; i < ENTRY_COUNT; i++) begin
      apply_entry(i);
    end
    $display("tests %0d checks %0d errors %0d", ENTRY_COUNT, check_count, error_count);
    if (error_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // Ends a hung run
  initial begin
    #(WATCHDOG_NS);
    $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

//--- sim.f
source/spi_pkg.sv
source/spi_command_decode.sv
source/spi_shift_engine.sv
source/spi_result_capture.sv
source/spi_echo_subordinate.sv
source/spi_subsystem.sv
tests/spi_subsystem_tb.sv

//--- Bender.yml
package:
  name: spi_subsystem

sources:
  # Package first, then leaf blocks, then the top level
  - files:
      - source/spi_pkg.sv
      - source/spi_command_decode.sv
      - source/spi_shift_engine.sv
      - source/spi_result_capture.sv
      - source/spi_echo_subordinate.sv
      - source/spi_subsystem.sv

  # Testbench, top module spi_subsystem_tb
  - target: test
    files:
      - tests/spi_subsystem_tb.sv
